// ==== uart_lite.f ====
hw/uart_pkg.sv
hw/baud_tick_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_fifo.sv
hw/uart_axil_regs.sv
hw/uart_top.sv
bench/uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module uart_tb -f uart_lite.f -o uart_sim

# The simulator exits non-zero on a failed check, so keep its output either way
output=$(./obj_dir/uart_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q -x -F "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

// ==== bench/uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tb;
  import uart_pkg::*;

  localparam int BUS_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 40000;
  localparam int POLL_LIMIT    = 1000;
  localparam int FRAME_LEN     = DATA_BITS + 2;  // Start, data, stop

  logic     clk;
  logic     rst;
  axil_aw_t aw;
  logic     awready;
  axil_w_t  w;
  logic     wready;
  axil_b_t  b;
  logic     bready;
  axil_ar_t ar;
  logic     arready;
  axil_r_t  r;
  logic     rready;
  logic     rx;
  logic     tx;

  logic [31:0]          lfsr_state;
  int                   cur_div;     // Divisor last written to the DUT
  logic                 mon_busy;    // Monitor is inside a frame
  logic [DATA_BITS-1:0] tx_exp_q[$]; // Bytes expected on tx, in write order

  uart_top UUT (
    .clk(clk), .rst(rst),
    .aw(aw), .awready(awready), .w(w), .wready(wready), .b(b), .bready(bready),
    .ar(ar), .arready(arready), .r(r), .rready(rready),
    .rx(rx), .tx(tx)
  );

  always #10 clk = ~clk;

  // Line image of one 8N1 frame, bit 0 goes first
  function automatic logic [FRAME_LEN-1:0] frame_bits(input logic [DATA_BITS-1:0] data);
    return {1'b1, data, 1'b0};
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  function automatic logic [DATA_BITS-1:0] random_byte();
    logic [DATA_BITS-1:0] value;
    value = '0;
    for (int i = 0; i < DATA_BITS; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);  // One step per bit
      value      = {value[DATA_BITS-2:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic uart_status_t make_status(input logic rxv, input logic rxf,
                                               input logic txf, input logic txb,
                                               input logic ovr, input logic ferr);
    return '{frame_err: ferr, rx_overrun: ovr, tx_busy: txb,
             tx_full: txf, rx_full: rxf, rx_valid: rxv};
  endfunction

  task automatic stop_with_fail(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [DATA_BITS-1:0] expected,
                            input logic [DATA_BITS-1:0] actual);
    if (actual !== expected)
      stop_with_fail($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic check_status(input string name, input uart_status_t expected,
                              input uart_status_t actual);
    if (actual !== expected)
      stop_with_fail($sformatf("FAIL %s: expected %b, actual %b", name, expected, actual));
  endtask

  task automatic check_resp(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
    if (actual !== expected)
      stop_with_fail($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic check_divisor(input string name, input logic [DIV_WIDTH-1:0] expected,
                               input logic [DIV_WIDTH-1:0] actual);
    if (actual !== expected)
      stop_with_fail($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic check_frame(input string name, input logic [FRAME_LEN-1:0] expected,
                             input logic [FRAME_LEN-1:0] actual);
    if (actual !== expected)
      stop_with_fail($sformatf("FAIL %s: expected %b, actual %b", name, expected, actual));
  endtask

  // hold is the number of cycles bready stays low once the response is up
  task automatic axil_write(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                            input int hold, output logic [1:0] resp);
    int count;
    aw     = '{valid: 1'b1, addr: addr};
    w      = '{valid: 1'b1, data: data, strb: 4'hF};
    bready = (hold == 0);
    count  = 0;
    @(negedge clk);
    while (!(awready && wready))
    begin
      count++;
      if (count > BUS_TIMEOUT)
        stop_with_fail("Timeout waiting for awready and wready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    aw    = '0;
    w     = '0;
    count = 0;
    @(negedge clk);
    while (!b.valid)
    begin
      count++;
      if (count > BUS_TIMEOUT)
        stop_with_fail("Timeout waiting for bvalid");
      @(negedge clk);
    end
    resp = b.resp;
    repeat (hold)
    begin
      @(negedge clk);
      if (!b.valid || b.resp !== resp)
        stop_with_fail("Write response changed while bready was low");
    end
    if (hold > 0)
    begin
      @(posedge clk);
      #1;
      bready = 1'b1;
    end
    count = 0;
    @(negedge clk);
    while (b.valid)
    begin
      count++;
      if (count > BUS_TIMEOUT)
        stop_with_fail("bvalid stayed high after bready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic axil_read(input logic [ADDR_WIDTH-1:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
    int count;
    ar     = '{valid: 1'b1, addr: addr};
    rready = (hold == 0);
    count  = 0;
    @(negedge clk);
    while (!arready)
    begin
      count++;
      if (count > BUS_TIMEOUT)
        stop_with_fail("Timeout waiting for arready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    ar    = '0;
    count = 0;
    @(negedge clk);
    while (!r.valid)
    begin
      count++;
      if (count > BUS_TIMEOUT)
        stop_with_fail("Timeout waiting for rvalid");
      @(negedge clk);
    end
    data = r.data;
    resp = r.resp;
    repeat (hold)
    begin
      @(negedge clk);
      if (!r.valid || r.data !== data || r.resp !== resp)
        stop_with_fail("Read response changed while rready was low");
    end
    if (hold > 0)
    begin
      @(posedge clk);
      #1;
      rready = 1'b1;
    end
    count = 0;
    @(negedge clk);
    while (r.valid)
    begin
      count++;
      if (count > BUS_TIMEOUT)
        stop_with_fail("rvalid stayed high after rready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic read_status(output uart_status_t st);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(REG_STATUS, 0, data, resp);
    check_resp("status read resp", RESP_OKAY, resp);
    st = data[$bits(uart_status_t)-1:0];
  endtask

  task automatic set_divisor(input int value);
    logic [1:0] resp;
    axil_write(REG_DIVISOR, 32'(value), 0, resp);
    check_resp("divisor write resp", RESP_OKAY, resp);
    cur_div = value;
  endtask

  task automatic hold_rx(input logic value, input int clocks);
    rx = value;
    repeat (clocks) @(posedge clk);
    #1;
  endtask

  // Low stop bit ends early so the receiver sees a glitch, not a new start
  task automatic send_frame(input logic [DATA_BITS-1:0] data, input logic stop_ok);
    logic [FRAME_LEN-1:0] image;
    int                   bit_clocks;
    image      = frame_bits(data);
    bit_clocks = OVERSAMPLE * (cur_div + 1);
    for (int i = 0; i < FRAME_LEN - 1; i++)
      hold_rx(image[i], bit_clocks);
    if (stop_ok)
      hold_rx(1'b1, bit_clocks);
    else
    begin
      hold_rx(1'b0, bit_clocks * 3 / 4);
      hold_rx(1'b1, bit_clocks * 5 / 4);
    end
  endtask

  task automatic wait_tx_drained();
    int count;
    count = 0;
    @(negedge clk);
    while (tx_exp_q.size() != 0 || mon_busy)
    begin
      count++;
      if (count > DRAIN_TIMEOUT)
        stop_with_fail("Timeout waiting for the expected frames on tx");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_tx_idle();
    uart_status_t st;
    int           polls;
    polls = 0;
    read_status(st);
    while (st.tx_busy)
    begin
      polls++;
      if (polls > POLL_LIMIT)
        stop_with_fail("Timeout waiting for tx_busy to clear");
      read_status(st);
    end
  endtask

  // Samples tx at bit centres and compares each frame in write order
  initial
  begin : tx_monitor
    logic [FRAME_LEN-1:0] image;
    int                   bit_clocks;
    forever
    begin
      @(negedge clk);
      if (!rst && tx === 1'b0)
      begin
        mon_busy   = 1'b1;
        bit_clocks = OVERSAMPLE * (cur_div + 1);
        repeat (bit_clocks / 2) @(negedge clk);
        image[0] = tx;
        for (int i = 1; i < FRAME_LEN; i++)
        begin
          repeat (bit_clocks) @(negedge clk);
          image[i] = tx;
        end
        if (tx_exp_q.size() == 0)
          stop_with_fail("A frame appeared on tx with no byte written for it");
        else
          check_frame("tx frame", frame_bits(tx_exp_q.pop_front()), image);
        mon_busy = 1'b0;
      end
    end
  end

  initial
  begin : main
    logic [31:0]          data;
    logic [1:0]           resp;
    uart_status_t         st;
    logic [DATA_BITS-1:0] value;
    logic [DATA_BITS-1:0] rx_exp_q[$];

    clk        = 1'b0;
    rst        = 1'b1;
    aw         = '0;
    w          = '0;
    ar         = '0;
    bready     = 1'b0;
    rready     = 1'b0;
    rx         = 1'b1;  // Idle line
    lfsr_state = 32'hea0e_ebdf;
    cur_div    = int'(DIV_RESET);
    mon_busy   = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // Reset values
    axil_read(REG_DIVISOR, 0, data, resp);
    check_resp("reset divisor resp", RESP_OKAY, resp);
    check_divisor("reset divisor", DIV_RESET, data[DIV_WIDTH-1:0]);
    read_status(st);
    check_status("reset status", '0, st);
    if (tx !== 1'b1)
      stop_with_fail("tx is not high after reset");

    // Transmit at two bit rates
    for (int pass = 0; pass < 2; pass++)
    begin
      set_divisor(pass == 0 ? 1 : 3);
      for (int i = 0; i < 4; i++)
      begin
        value = random_byte();
        tx_exp_q.push_back(value);
        axil_write(REG_TXDATA, 32'(value), 0, resp);
        check_resp($sformatf("tx write %0d", i), RESP_OKAY, resp);
      end
      wait_tx_drained();
      wait_tx_idle();
    end

    // Receive
    set_divisor(2);
    for (int i = 0; i < 5; i++)
    begin
      value = random_byte();
      rx_exp_q.push_back(value);
      send_frame(value, 1'b1);
    end
    for (int i = 0; i < 5; i++)
    begin
      axil_read(REG_RXDATA, 0, data, resp);
      check_resp($sformatf("rx read resp %0d", i), RESP_OKAY, resp);
      check_byte($sformatf("rx byte %0d", i), rx_exp_q.pop_front(), data[DATA_BITS-1:0]);
    end
    read_status(st);
    check_status("status after rx drain", '0, st);

    // Overrun, then a bad stop bit on top of it
    for (int i = 0; i < FIFO_DEPTH + 1; i++)
    begin
      value = random_byte();
      rx_exp_q.push_back(value);
      send_frame(value, 1'b1);
    end
    send_frame(random_byte(), 1'b0);
    read_status(st);
    check_status("overrun and framing", make_status(1, 1, 0, 0, 1, 1), st);
    read_status(st);
    check_status("sticky bits cleared", make_status(1, 1, 0, 0, 0, 0), st);
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      axil_read(REG_RXDATA, 0, data, resp);
      check_byte($sformatf("overrun byte %0d", i), rx_exp_q.pop_front(), data[DATA_BITS-1:0]);
    end
    rx_exp_q.delete();  // Last byte was dropped by the DUT
    read_status(st);
    check_status("status after overrun drain", '0, st);

    // Bus errors
    axil_write(REG_RXDATA, 32'h0000_005a, 0, resp);
    check_resp("write to rxdata", RESP_SLVERR, resp);
    axil_write(REG_STATUS, 32'h0000_003f, 0, resp);
    check_resp("write to status", RESP_SLVERR, resp);
    axil_read(REG_TXDATA, 0, data, resp);
    check_resp("read of txdata", RESP_SLVERR, resp);

    // One byte in the transmitter plus a full FIFO
    set_divisor(1);
    for (int i = 0; i < FIFO_DEPTH + 1; i++)
    begin
      value = random_byte();
      tx_exp_q.push_back(value);
      axil_write(REG_TXDATA, 32'(value), 0, resp);
      check_resp($sformatf("fill write %0d", i), RESP_OKAY, resp);
    end
    read_status(st);
    check_status("tx fifo full", make_status(0, 0, 1, 1, 0, 0), st);
    axil_write(REG_TXDATA, 32'(random_byte()), 0, resp);
    check_resp("write while tx full", RESP_SLVERR, resp);
    wait_tx_drained();
    wait_tx_idle();  // An extra frame here would trip the monitor

    // Back-pressure on both response channels
    axil_read(REG_DIVISOR, 8, data, resp);
    check_resp("held read resp", RESP_OKAY, resp);
    check_divisor("held read data", DIV_WIDTH'(cur_div), data[DIV_WIDTH-1:0]);
    axil_write(REG_DIVISOR, 32'(cur_div), 8, resp);
    check_resp("held write resp", RESP_OKAY, resp);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_top (
  input  logic               clk,
  input  logic               rst,
  input  uart_pkg::axil_aw_t aw,
  output logic               awready,
  input  uart_pkg::axil_w_t  w,
  output logic               wready,
  output uart_pkg::axil_b_t  b,
  input  logic               bready,
  input  uart_pkg::axil_ar_t ar,
  output logic               arready,
  output uart_pkg::axil_r_t  r,
  input  logic               rready,
  input  logic               rx,
  output logic               tx
);
  import uart_pkg::*;

  logic                 tick;
  logic [DIV_WIDTH-1:0] divisor;
  logic                 tx_push;
  logic [DATA_BITS-1:0] tx_push_data;
  logic                 tx_full;
  logic                 tx_empty;
  logic                 tx_pop;
  logic [DATA_BITS-1:0] tx_head;
  logic                 tx_ready;
  logic                 tx_active;
  logic                 rx_pop;
  logic [DATA_BITS-1:0] rx_pop_data;
  logic                 rx_empty;
  logic                 rx_full;
  logic                 rx_done;
  logic [DATA_BITS-1:0] rx_data;
  logic                 frame_err;

  assign tx_pop = !tx_empty && tx_ready;  // Transmitter takes the head when idle

  baud_tick_gen u_tick (.clk(clk), .rst(rst), .divisor(divisor), .tick(tick));

  uart_rx u_rx (
    .clk(clk), .rst(rst), .rx(rx), .tick(tick),
    .rx_done(rx_done), .rx_data(rx_data), .frame_err(frame_err)
  );

  uart_tx u_tx (
    .clk(clk), .rst(rst), .tick(tick),
    .tx_valid(!tx_empty), .tx_data(tx_head), .tx_ready(tx_ready),
    .tx(tx), .busy(tx_active)
  );

  // Receive side never stalls, a full FIFO drops the byte
  uart_fifo u_rx_fifo (
    .clk(clk), .rst(rst), .push(rx_done), .push_data(rx_data),
    .pop(rx_pop), .pop_data(rx_pop_data), .empty(rx_empty), .full(rx_full)
  );

  uart_fifo u_tx_fifo (
    .clk(clk), .rst(rst), .push(tx_push), .push_data(tx_push_data),
    .pop(tx_pop), .pop_data(tx_head), .empty(tx_empty), .full(tx_full)
  );

  uart_axil_regs u_regs (
    .clk(clk), .rst(rst),
    .aw(aw), .awready(awready), .w(w), .wready(wready), .b(b), .bready(bready),
    .ar(ar), .arready(arready), .r(r), .rready(rready),
    .tx_push(tx_push), .tx_push_data(tx_push_data), .tx_full(tx_full),
    .rx_pop(rx_pop), .rx_pop_data(rx_pop_data), .rx_empty(rx_empty),
    .rx_full(rx_full), .rx_done(rx_done), .frame_err_pulse(frame_err),
    .tx_busy(tx_active || !tx_empty), .divisor(divisor)
  );

endmodule

`default_nettype wire

// ==== hw/uart_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_axil_regs (
  input  logic                           clk,
  input  logic                           rst,
  input  uart_pkg::axil_aw_t             aw,
  output logic                           awready,
  input  uart_pkg::axil_w_t              w,
  output logic                           wready,
  output uart_pkg::axil_b_t              b,
  input  logic                           bready,
  input  uart_pkg::axil_ar_t             ar,
  output logic                           arready,
  output uart_pkg::axil_r_t              r,
  input  logic                           rready,
  output logic                           tx_push,
  output logic [uart_pkg::DATA_BITS-1:0] tx_push_data,
  input  logic                           tx_full,
  output logic                           rx_pop,
  input  logic [uart_pkg::DATA_BITS-1:0] rx_pop_data,
  input  logic                           rx_empty,
  input  logic                           rx_full,
  input  logic                           rx_done,
  input  logic                           frame_err_pulse,
  input  logic                           tx_busy,
  output logic [uart_pkg::DIV_WIDTH-1:0] divisor
);
  import uart_pkg::*;

  logic                 wr_accept;
  logic                 rd_accept;
  logic [1:0]           wr_resp;
  logic [1:0]           rd_resp;
  logic [31:0]          rd_data;
  logic                 status_rd;  // Status read accepted this cycle
  logic                 b_valid;
  logic [1:0]           b_resp;
  logic                 r_valid;
  logic [31:0]          r_data;
  logic [1:0]           r_resp;
  logic                 overrun_flag;
  logic                 frame_err_flag;
  logic [DIV_WIDTH-1:0] div_reg;
  uart_status_t         status;

  // Both write channels taken together, never under a pending response
  assign wr_accept = aw.valid && w.valid && !b_valid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign rd_accept = ar.valid && !r_valid;
  assign arready   = rd_accept;

  assign status = '{frame_err:  frame_err_flag,
                    rx_overrun: overrun_flag,
                    tx_busy:    tx_busy,
                    tx_full:    tx_full,
                    rx_full:    rx_full,
                    rx_valid:   !rx_empty};

  always_comb
  begin
    wr_resp = RESP_SLVERR;  // Read-only and unmapped offsets
    tx_push = 1'b0;
    case (aw.addr)
      REG_TXDATA:
        if (!tx_full)
        begin
          wr_resp = RESP_OKAY;
          tx_push = wr_accept;
        end
      REG_DIVISOR:
        wr_resp = RESP_OKAY;
      default:
        wr_resp = RESP_SLVERR;
    endcase
  end

  assign tx_push_data = w.data[DATA_BITS-1:0];

  always_comb
  begin
    rd_data   = '0;
    rd_resp   = RESP_OKAY;
    rx_pop    = 1'b0;
    status_rd = 1'b0;
    case (ar.addr)
      REG_RXDATA:
      begin
        rx_pop = rd_accept && !rx_empty;
        if (!rx_empty)
          rd_data[DATA_BITS-1:0] = rx_pop_data;  // Zero when nothing waits
      end
      REG_STATUS:
      begin
        rd_data[$bits(uart_status_t)-1:0] = status;
        status_rd = rd_accept;
      end
      REG_DIVISOR:
        rd_data[DIV_WIDTH-1:0] = div_reg;
      default:
        rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      b_valid <= 1'b0;
    else if (wr_accept)
      b_valid <= 1'b1;
    else if (bready)
      b_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (wr_accept)
      b_resp <= wr_resp;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      r_valid <= 1'b0;
    else if (rd_accept)
      r_valid <= 1'b1;
    else if (rready)
      r_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (rd_accept)
    begin
      r_data <= rd_data;
      r_resp <= rd_resp;
    end
  end

  // Byte lanes of the divisor follow the write strobes
  always_ff @(posedge clk)
  begin
    if (rst)
      div_reg <= DIV_RESET;
    else if (wr_accept && aw.addr == REG_DIVISOR)
    begin
      for (int i = 0; i < DIV_WIDTH / 8; i++)
      begin
        if (w.strb[i])
          div_reg[i*8 +: 8] <= w.data[i*8 +: 8];
      end
    end
  end

  // Sticky flags; a new event in the clearing cycle survives
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      overrun_flag   <= 1'b0;
      frame_err_flag <= 1'b0;
    end
    else
    begin
      overrun_flag   <= (overrun_flag && !status_rd) || (rx_done && rx_full);
      frame_err_flag <= (frame_err_flag && !status_rd) || frame_err_pulse;
    end
  end

  assign b       = '{valid: b_valid, resp: b_resp};
  assign r       = '{valid: r_valid, data: r_data, resp: r_resp};
  assign divisor = div_reg;

endmodule

`default_nettype wire

// ==== hw/uart_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_fifo (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           push,
  input  logic [uart_pkg::DATA_BITS-1:0] push_data,
  input  logic                           pop,
  output logic [uart_pkg::DATA_BITS-1:0] pop_data,
  output logic                           empty,
  output logic                           full
);
  import uart_pkg::*;

  logic [DATA_BITS-1:0]      mem [FIFO_DEPTH];
  logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
  logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
  logic [FIFO_CNT_WIDTH-1:0] count;
  logic                      do_push;
  logic                      do_pop;

  assign do_push = push && !full;   // Dropped when full
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, wraps freely
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign pop_data = mem[rd_ptr];  // Head entry
  assign empty    = (count == '0);
  assign full     = (count == FIFO_CNT_WIDTH'(FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           tick,
  input  logic                           tx_valid,
  input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
  output logic                           tx_ready,
  output logic                           tx,
  output logic                           busy
);
  import uart_pkg::*;

  uart_state_t              state_reg, state_next;
  logic [TICK_WIDTH-1:0]    s_reg, s_next;
  logic [BIT_CNT_WIDTH-1:0] n_reg, n_next;
  logic [DATA_BITS-1:0]     b_reg, b_next;  // Remaining bits, LSB goes next
  logic                     tx_reg, tx_next;
  logic                     loaded_reg, loaded_next;  // Byte held until the next tick

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_reg  <= ST_IDLE;
      s_reg      <= '0;
      n_reg      <= '0;
      tx_reg     <= 1'b1;
      loaded_reg <= 1'b0;
    end
    else
    begin
      state_reg  <= state_next;
      s_reg      <= s_next;
      n_reg      <= n_next;
      tx_reg     <= tx_next;
      loaded_reg <= loaded_next;
    end
  end

  always_ff @(posedge clk)
    b_reg <= b_next;

  always_comb
  begin
    state_next  = state_reg;
    s_next      = s_reg;
    n_next      = n_reg;
    b_next      = b_reg;
    tx_next     = tx_reg;
    loaded_next = loaded_reg;

    case (state_reg)
      ST_IDLE:
      begin
        tx_next = 1'b1;
        if (tx_valid && tx_ready)
        begin
          b_next      = tx_data;
          loaded_next = 1'b1;
        end
        // Start bit begins on a tick so every bit is a full 16 ticks
        if (tick && loaded_reg)
        begin
          state_next  = ST_START;
          s_next      = '0;
          tx_next     = 1'b0;
          loaded_next = 1'b0;
        end
      end
      ST_START:
        if (tick)
        begin
          if (s_reg == TICK_LAST)
          begin
            state_next = ST_DATA;
            s_next     = '0;
            n_next     = '0;
            tx_next    = b_reg[0];
          end
          else
            s_next = s_reg + 1'b1;
        end
      ST_DATA:
        if (tick)
        begin
          if (s_reg == TICK_LAST)
          begin
            s_next = '0;
            if (n_reg == BIT_LAST)
            begin
              state_next = ST_STOP;
              tx_next    = 1'b1;
            end
            else
            begin
              n_next  = n_reg + 1'b1;
              b_next  = b_reg >> 1;
              tx_next = b_reg[1];
            end
          end
          else
            s_next = s_reg + 1'b1;
        end
      ST_STOP:
        if (tick)
        begin
          if (s_reg == TICK_LAST)
            state_next = ST_IDLE;
          else
            s_next = s_reg + 1'b1;
        end
      default:
        state_next = ST_IDLE;
    endcase
  end

  assign tx_ready = (state_reg == ST_IDLE) && !loaded_reg;
  assign busy     = (state_reg != ST_IDLE) || loaded_reg;
  assign tx       = tx_reg;

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           rx,
  input  logic                           tick,
  output logic                           rx_done,
  output logic [uart_pkg::DATA_BITS-1:0] rx_data,
  output logic                           frame_err
);
  import uart_pkg::*;

  uart_state_t              state_reg, state_next;
  logic [TICK_WIDTH-1:0]    s_reg, s_next;  // Ticks into the current bit
  logic [BIT_CNT_WIDTH-1:0] n_reg, n_next;  // Data bits taken
  logic [DATA_BITS-1:0]     b_reg, b_next;  // Byte being assembled
  logic [1:0]               rx_sync;
  logic                     rx_s;

  // Two-flop synchronizer on the pin, idle level is high
  always_ff @(posedge clk)
  begin
    if (rst)
      rx_sync <= 2'b11;
    else
      rx_sync <= {rx_sync[0], rx};
  end

  assign rx_s = rx_sync[1];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_reg <= ST_IDLE;
      s_reg     <= '0;
      n_reg     <= '0;
    end
    else
    begin
      state_reg <= state_next;
      s_reg     <= s_next;
      n_reg     <= n_next;
    end
  end

  always_ff @(posedge clk)
    b_reg <= b_next;

  always_comb
  begin
    state_next = state_reg;
    s_next     = s_reg;
    n_next     = n_reg;
    b_next     = b_reg;
    rx_done    = 1'b0;
    frame_err  = 1'b0;

    case (state_reg)
      ST_IDLE:
        if (!rx_s)
        begin
          state_next = ST_START;
          s_next     = '0;
        end
      ST_START:
        if (tick)
        begin
          if (s_reg == TICK_MID)
          begin
            // High at the centre means a glitch, not a start bit
            state_next = rx_s ? ST_IDLE : ST_DATA;
            s_next     = '0;
            n_next     = '0;
          end
          else
            s_next = s_reg + 1'b1;
        end
      ST_DATA:
        if (tick)
        begin
          if (s_reg == TICK_LAST)
          begin
            s_next = '0;
            b_next = {rx_s, b_reg[DATA_BITS-1:1]};  // LSB first
            if (n_reg == BIT_LAST)
              state_next = ST_STOP;
            else
              n_next = n_reg + 1'b1;
          end
          else
            s_next = s_reg + 1'b1;
        end
      ST_STOP:
        if (tick)
        begin
          if (s_reg == TICK_LAST)
          begin
            state_next = ST_IDLE;
            rx_done    = 1'b1;
            frame_err  = !rx_s;  // Byte still delivered
          end
          else
            s_next = s_reg + 1'b1;
        end
      default:
        state_next = ST_IDLE;
    endcase
  end

  assign rx_data = b_reg;

endmodule

`default_nettype wire

// ==== hw/baud_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [uart_pkg::DIV_WIDTH-1:0] divisor,
  output logic                           tick
);
  import uart_pkg::*;

  logic [DIV_WIDTH-1:0] count;  // Clocks left before the next tick

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      tick  <= 1'b0;
    end
    else if (count == '0)
    begin
      count <= divisor;  // Divisor changes land here
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // Frame format, 8N1 only
  localparam int DATA_BITS     = 8;
  localparam int OVERSAMPLE    = 16;
  localparam int TICK_WIDTH    = $clog2(OVERSAMPLE);
  localparam int BIT_CNT_WIDTH = $clog2(DATA_BITS);

  localparam logic [TICK_WIDTH-1:0]    TICK_MID  = TICK_WIDTH'(OVERSAMPLE / 2 - 1);
  localparam logic [TICK_WIDTH-1:0]    TICK_LAST = TICK_WIDTH'(OVERSAMPLE - 1);
  localparam logic [BIT_CNT_WIDTH-1:0] BIT_LAST  = BIT_CNT_WIDTH'(DATA_BITS - 1);

  localparam int FIFO_DEPTH     = 8;
  localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH = FIFO_PTR_WIDTH + 1;

  localparam int DIV_WIDTH = 16;
  localparam logic [DIV_WIDTH-1:0] DIV_RESET = DIV_WIDTH'(1);

  // Register map
  localparam int ADDR_WIDTH = 4;
  localparam logic [ADDR_WIDTH-1:0] REG_TXDATA  = 4'h0;  // Write only
  localparam logic [ADDR_WIDTH-1:0] REG_RXDATA  = 4'h4;  // Read pops the RX FIFO
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS  = 4'h8;  // Read clears sticky bits
  localparam logic [ADDR_WIDTH-1:0] REG_DIVISOR = 4'hC;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Shared by the receiver and the transmitter
  typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} uart_state_t;

  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [3:0]  strb;
  } axil_w_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [1:0]  resp;
  } axil_r_t;

  // Bit 0 is rx_valid
  typedef struct packed {
    logic frame_err;
    logic rx_overrun;
    logic tx_busy;
    logic tx_full;
    logic rx_full;
    logic rx_valid;
  } uart_status_t;

endpackage

`default_nettype wire
